// File: dividerCounter.sv
`default_nettype none

`include "timer_macros.svh"

module dividerCounter
    import timer_pkg::*;
(
    input  wire                         iClock,
    input  wire                         arstN,
    input  wire regWrite_t              regWrite,
    output logic [`TIMER_DATA_W-1:0]    div
);

    // Free-running system counter, DIV is its upper byte
    logic [`TIMER_SYS_W-1:0] sysCount;
    logic                    divWrite;

    // Only strobes addressed to DIV matter here, the data is ignored
    assign divWrite = regWrite.valid && (regWrite.addr == REG_DIV);

    // ------------------------------------------------------------------------
    // System counter
    // ------------------------------------------------------------------------

    always_ff @(posedge iClock or negedge arstN)
    begin
        if (!arstN)
        begin
            sysCount <= '0;
        end
        else if (divWrite)
        begin
            // Clearing the full counter puts the next DIV step 256 cycles away
            sysCount <= '0;
        end
        else
        begin
            sysCount <= sysCount + 1'b1;
        end
    end

    assign div = sysCount[`TIMER_SYS_W-1 -: `TIMER_DATA_W];

endmodule

`default_nettype wire

// File: gbTimer.sv
`default_nettype none

`include "timer_macros.svh"

module gbTimer
    import timer_pkg::*;
(
    input  wire                         iClock,
    input  wire                         arstN,
    input  wire                         req,
    input  wire regReq_t                busReq,
    output logic                        ack,
    output logic [`TIMER_DATA_W-1:0]    rdata,
    output logic                        irqTimer
);

    regWrite_t                  regWrite;
    timerRegs_t                 regs;
    logic [`TIMER_DATA_W-1:0]   div;
    logic [`TIMER_DATA_W-1:0]   tima;
    logic [`TIMER_DATA_W-1:0]   tma;
    tacCfg_t                    tac;

    // ------------------------------------------------------------------------
    // Bus side
    // ------------------------------------------------------------------------

    regBusSlave busSlave_i
    (
        .iClock     (iClock),
        .arstN      (arstN),
        .req        (req),
        .busReq     (busReq),
        .regs       (regs),
        .ack        (ack),
        .rdata      (rdata),
        .regWrite   (regWrite)
    );

    // TAC reads back zero-extended
    assign regs = '{div: div, tima: tima, tma: tma, tac: `TIMER_DATA_W'(tac)};

    // ------------------------------------------------------------------------
    // Counter units
    // ------------------------------------------------------------------------

    dividerCounter divider_i
    (
        .iClock     (iClock),
        .arstN      (arstN),
        .regWrite   (regWrite),
        .div        (div)
    );

    timaCounter tima_i
    (
        .iClock     (iClock),
        .arstN      (arstN),
        .regWrite   (regWrite),
        .tima       (tima),
        .tma        (tma),
        .tac        (tac),
        .irqTimer   (irqTimer)
    );

endmodule

`default_nettype wire

// File: list.f
+incdir+.
timer_pkg.sv
regBusSlave.sv
dividerCounter.sv
timaCounter.sv
gbTimer.sv
tb_gbTimer.sv

// File: regBusSlave.sv
`default_nettype none

`include "timer_macros.svh"

module regBusSlave
    import timer_pkg::*;
(
    input  wire                             iClock,
    input  wire                             arstN,
    input  wire                             req,
    input  wire regReq_t                    busReq,
    input  wire timerRegs_t                 regs,
    output logic                            ack,
    output logic [`TIMER_DATA_W-1:0]        rdata,
    output regWrite_t                       regWrite
);

    // Access happens once, on the edge that sees req high with ack still low
    logic                       accept;
    logic [`TIMER_DATA_W-1:0]   readData;
    logic                       writeValid;
    regAddr_e                   writeAddr;
    logic [`TIMER_DATA_W-1:0]   writeData;

    assign accept = req && !ack;

    // ------------------------------------------------------------------------
    // Four-phase handshake
    // ------------------------------------------------------------------------

    always_ff @(posedge iClock or negedge arstN)
    begin
        if (!arstN)
        begin
            ack <= 1'b0;
        end
        else if (accept)
        begin
            ack <= 1'b1;
        end
        else if (!req)
        begin
            // Return to zero once the master lets go
            ack <= 1'b0;
        end
    end

    // ------------------------------------------------------------------------
    // Read path
    // ------------------------------------------------------------------------

    always_comb
    begin
        readData = regs.div;
        case (busReq.addr)
            REG_DIV:
            begin
                readData = regs.div;
            end
            REG_TIMA:
            begin
                readData = regs.tima;
            end
            REG_TMA:
            begin
                readData = regs.tma;
            end
            REG_TAC:
            begin
                readData = regs.tac;
            end
        endcase
    end

    // Sampled at the accepting edge and held while ack is high
    always_ff @(posedge iClock)
    begin
        if (accept)
        begin
            rdata <= readData;
        end
    end

    // ------------------------------------------------------------------------
    // Write strobe
    // ------------------------------------------------------------------------

    // Valid for exactly one cycle per accepted write
    always_ff @(posedge iClock or negedge arstN)
    begin
        if (!arstN)
        begin
            writeValid <= 1'b0;
        end
        else
        begin
            writeValid <= accept && busReq.write;
        end
    end

    always_ff @(posedge iClock)
    begin
        if (accept)
        begin
            writeAddr <= busReq.addr;
            writeData <= busReq.wdata;
        end
    end

    assign regWrite = '{valid: writeValid, addr: writeAddr, data: writeData};

endmodule

`default_nettype wire

// File: tb_gbTimerTasks.svh
`ifndef TB_GBTIMERTASKS_SVH
`define TB_GBTIMERTASKS_SVH

// ------------------------------------------------------------------------
// Bus master tasks start and end right after a rising edge
// ------------------------------------------------------------------------

task automatic waitAck(input logic level);
    int cycles;
    for (cycles = 0; cycles < ackTimeout; cycles++)
    begin
        @(posedge iClock);
        if (ack === level)
            break;
    end
    if (ack !== level)
    begin
        $display("Timeout while waiting for ack to become %0b", level);
        errorCount++;
    end
endtask

task automatic busWrite(input regAddr_e addr, input logic [`TIMER_DATA_W-1:0] data);
    req    <= 1'b1;
    busReq <= {1'b1, addr, data};
    waitAck(1'b1);
    req <= 1'b0;
    waitAck(1'b0);
endtask

task automatic busRead(input regAddr_e addr, output logic [`TIMER_DATA_W-1:0] data);
    req    <= 1'b1;
    busReq <= {1'b0, addr, {`TIMER_DATA_W{1'b0}}};
    waitAck(1'b1);
    // Registered at the accepting edge and held while ack is high
    data = rdata;
    req <= 1'b0;
    waitAck(1'b0);
endtask

// ------------------------------------------------------------------------
// Compare tasks and random numbers
// ------------------------------------------------------------------------

task automatic checkData(input string name, input logic [`TIMER_DATA_W-1:0] got,
                         input logic [`TIMER_DATA_W-1:0] expected);
    if (got !== expected)
    begin
        $display("Mismatch %s expected 0x%02h got 0x%02h", name, expected, got);
        errorCount++;
    end
endtask

task automatic checkTac(input string name, input tacCfg_t got, input tacCfg_t expected);
    if (got !== expected)
    begin
        $display("Mismatch %s expected 0x%01h got 0x%01h", name, expected, got);
        errorCount++;
    end
endtask

task automatic checkIrq(input string name, input logic got, input logic expected);
    if (got !== expected)
    begin
        $display("Mismatch %s expected 0x%01h got 0x%01h", name, expected, got);
        errorCount++;
    end
endtask

function automatic logic [31:0] xorshift();
    logic [31:0] x;
    x = rngState;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rngState = x;
    return x;
endfunction

// ------------------------------------------------------------------------
// Directed tests
// ------------------------------------------------------------------------

task automatic resetStateTest();
    logic [`TIMER_DATA_W-1:0] value;
    busRead(REG_DIV, value);
    checkData("DIV", value, 8'h00);
    busRead(REG_TIMA, value);
    checkData("TIMA", value, 8'h00);
    busRead(REG_TMA, value);
    checkData("TMA", value, 8'h00);
    busRead(REG_TAC, value);
    checkData("TAC", value, 8'h00);
    checkIrq("irqTimer", irqCount != 0, 1'b0);
endtask

task automatic registerReadBack();
    logic [31:0]              rand32;
    logic [`TIMER_DATA_W-1:0] tmaValue;
    logic [`TIMER_DATA_W-1:0] timaValue;
    logic [`TIMER_DATA_W-1:0] value;
    tacCfg_t                  tacValue;
    rand32    = xorshift();
    tmaValue  = rand32[7:0];
    timaValue = rand32[15:8];
    // Enable stays clear so TIMA holds still
    tacValue  = {1'b0, rand32[17:16]};
    busWrite(REG_TMA, tmaValue);
    busWrite(REG_TIMA, timaValue);
    busWrite(REG_TAC, {5'b00000, tacValue});
    busRead(REG_TMA, value);
    checkData("TMA", value, tmaValue);
    busRead(REG_TIMA, value);
    checkData("TIMA", value, timaValue);
    busRead(REG_TAC, value);
    checkTac("TAC", value[2:0], tacValue);
    checkData("TAC upper bits", {3'b000, value[7:3]}, 8'h00);
endtask

task automatic divRateAndClear();
    logic [`TIMER_DATA_W-1:0] value;
    logic [`TIMER_DATA_W-1:0] steps;
    steps = 8'd3;
    busWrite(REG_DIV, 8'h5a);
    repeat (256 * steps) @(posedge iClock);
    busRead(REG_DIV, value);
    // Bus latency may add one step
    if (value !== steps && value !== steps + 8'd1)
        checkData("DIV", value, steps);
    busWrite(REG_DIV, 8'h00);
    busRead(REG_DIV, value);
    checkData("DIV", value, 8'h00);
endtask

task automatic timaRateAndEnable();
    logic [`TIMER_DATA_W-1:0] value;
    logic [`TIMER_DATA_W-1:0] first;
    logic [`TIMER_DATA_W-1:0] ticks;
    ticks = 8'd5;
    busWrite(REG_TIMA, 8'h00);
    // Enable with speed 1 for one tick per 16 cycles
    busWrite(REG_TAC, 8'h05);
    repeat (16 * ticks) @(posedge iClock);
    busRead(REG_TIMA, value);
    if (value !== ticks && value !== ticks + 8'd1)
        checkData("TIMA", value, ticks);
    busWrite(REG_TAC, 8'h01);
    busRead(REG_TIMA, first);
    repeat (100) @(posedge iClock);
    busRead(REG_TIMA, value);
    checkData("TIMA held", value, first);
endtask

task automatic overflowReload();
    logic [31:0]              rand32;
    logic [`TIMER_DATA_W-1:0] tmaValue;
    logic [`TIMER_DATA_W-1:0] value;
    int                       cycles;
    rand32   = xorshift();
    tmaValue = rand32[7:0];
    busWrite(REG_TMA, tmaValue);
    busWrite(REG_TIMA, 8'hfe);
    busWrite(REG_TAC, 8'h05);
    for (cycles = 0; cycles < irqTimeout; cycles++)
    begin
        @(posedge iClock);
        if (irqTimer === 1'b1)
            break;
    end
    if (irqTimer !== 1'b1)
    begin
        $display("Timeout while waiting for irqTimer after a TIMA overflow");
        errorCount++;
    end
    else
    begin
        @(posedge iClock);
        checkIrq("irqTimer", irqTimer, 1'b0);
        busRead(REG_TIMA, value);
        if (value !== tmaValue && value !== tmaValue + 8'd1)
            checkData("TIMA", value, tmaValue);
    end
    busWrite(REG_TAC, 8'h01);
endtask

task automatic writePriority();
    logic [`TIMER_DATA_W-1:0] value;
    int                       startIrqs;
    int                       i;
    busWrite(REG_TIMA, 8'hff);
    startIrqs = irqCount;
    // Back-to-back accesses repeat every 4 cycles, so each tick meets a TIMA write
    busWrite(REG_TAC, 8'h05);
    for (i = 0; i < 50; i++)
        busWrite(REG_TIMA, 8'hff);
    busWrite(REG_TAC, 8'h01);
    busRead(REG_TIMA, value);
    checkData("TIMA", value, 8'hff);
    checkIrq("irqTimer", irqCount != startIrqs, 1'b0);
endtask

`endif

// File: tb_gbTimer.sv
`default_nettype none

`include "timer_macros.svh"

module tb_gbTimer
    import timer_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int ackTimeout = 16;
    localparam int irqTimeout = 64;

    logic                       iClock;
    logic                       arstN;
    logic                       req;
    regReq_t                    busReq;
    logic                       ack;
    logic [`TIMER_DATA_W-1:0]   rdata;
    logic                       irqTimer;

    int                         errorCount = 0;
    int                         lastErrors = 0;
    int                         testCount = 0;
    int                         failedCount = 0;
    int                         irqCount = 0;
    logic [31:0]                rngState = 32'd76;

    gbTimer dut_i
    (
        .iClock     (iClock),
        .arstN      (arstN),
        .req        (req),
        .busReq     (busReq),
        .ack        (ack),
        .rdata      (rdata),
        .irqTimer   (irqTimer)
    );

    `include "tb_gbTimerTasks.svh"

    initial
    begin
        iClock = 1'b0;
        forever
        begin
            #5 iClock = ~iClock;
        end
    end

    // Counts timer interrupt pulses for the tests that watch them
    always @(posedge iClock)
    begin
        if (irqTimer === 1'b1)
            irqCount <= irqCount + 1;
    end

    // One line per finished test
    task automatic reportTest(input string name);
        testCount++;
        if (errorCount == lastErrors)
            $display("Test %s: ok", name);
        else
        begin
            failedCount++;
            $display("Test %s: %0d error(s)", name, errorCount - lastErrors);
        end
        lastErrors = errorCount;
    endtask

    initial
    begin
        arstN  = 1'b0;
        req    = 1'b0;
        busReq = '0;
        repeat (5) @(posedge iClock);
        arstN <= 1'b1;
        @(posedge iClock);

        resetStateTest();
        reportTest("reset state");
        registerReadBack();
        reportTest("register read-back");
        divRateAndClear();
        reportTest("DIV rate and clear");
        timaRateAndEnable();
        reportTest("TIMA rate and enable");
        overflowReload();
        reportTest("TIMA overflow");
        writePriority();
        reportTest("TIMA write priority");

        $display("Tests run %0d, failed %0d, errors %0d", testCount, failedCount, errorCount);
        if (errorCount == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: timaCounter.sv
`default_nettype none

`include "timer_macros.svh"

module timaCounter
    import timer_pkg::*;
(
    input  wire                         iClock,
    input  wire                         arstN,
    input  wire regWrite_t              regWrite,
    output logic [`TIMER_DATA_W-1:0]    tima,
    output logic [`TIMER_DATA_W-1:0]    tma,
    output tacCfg_t                     tac,
    output logic                        irqTimer
);

    logic                           writeTima;
    logic                           writeTma;
    logic                           writeTac;
    logic [`TIMER_PRESCALE_W-1:0]   prescale;
    logic [`TIMER_PRESCALE_W-1:0]   prescaleLast;
    logic                           tick;
    logic                           overflow;

    // Decode the strobes that belong to this unit
    assign writeTima = regWrite.valid && (regWrite.addr == REG_TIMA);
    assign writeTma  = regWrite.valid && (regWrite.addr == REG_TMA);
    assign writeTac  = regWrite.valid && (regWrite.addr == REG_TAC);

    // ------------------------------------------------------------------------
    // TMA and TAC
    // ------------------------------------------------------------------------

    always_ff @(posedge iClock or negedge arstN)
    begin
        if (!arstN)
        begin
            tma <= '0;
        end
        else if (writeTma)
        begin
            tma <= regWrite.data;
        end
    end

    // Upper TAC bits are not stored
    always_ff @(posedge iClock or negedge arstN)
    begin
        if (!arstN)
        begin
            tac <= '0;
        end
        else if (writeTac)
        begin
            tac <= tacCfg_t'(regWrite.data[`TIMER_TAC_W-1:0]);
        end
    end

    // ------------------------------------------------------------------------
    // Prescaler
    // ------------------------------------------------------------------------

    // Terminal count is the selected period minus one
    always_comb
    begin
        case (tac.speed)
            2'd0:
            begin
                prescaleLast = `TIMER_PRESCALE_W'(`TIMER_PERIOD_SPEED0 - 1);
            end
            2'd1:
            begin
                prescaleLast = `TIMER_PRESCALE_W'(`TIMER_PERIOD_SPEED1 - 1);
            end
            2'd2:
            begin
                prescaleLast = `TIMER_PRESCALE_W'(`TIMER_PERIOD_SPEED2 - 1);
            end
            default:
            begin
                prescaleLast = `TIMER_PRESCALE_W'(`TIMER_PERIOD_SPEED3 - 1);
            end
        endcase
    end

    assign tick = tac.enable && (prescale == prescaleLast);

    always_ff @(posedge iClock or negedge arstN)
    begin
        if (!arstN)
        begin
            prescale <= '0;
        end
        else if (writeTac || tick)
        begin
            // A new speed always starts from a full period
            prescale <= '0;
        end
        else if (tac.enable)
        begin
            prescale <= prescale + 1'b1;
        end
    end

    // ------------------------------------------------------------------------
    // TIMA and overflow
    // ------------------------------------------------------------------------

    assign overflow = tick && (tima == {`TIMER_DATA_W{1'b1}});

    // CPU write beats the count and also suppresses the reload
    always_ff @(posedge iClock or negedge arstN)
    begin
        if (!arstN)
        begin
            tima <= '0;
        end
        else if (writeTima)
        begin
            tima <= regWrite.data;
        end
        else if (overflow)
        begin
            tima <= tma;
        end
        else if (tick)
        begin
            tima <= tima + 1'b1;
        end
    end

    // High for the one cycle after the reload edge
    always_ff @(posedge iClock or negedge arstN)
    begin
        if (!arstN)
        begin
            irqTimer <= 1'b0;
        end
        else
        begin
            irqTimer <= overflow && !writeTima;
        end
    end

endmodule

`default_nettype wire

// File: timer_macros.svh
`ifndef TIMER_MACROS_SVH
`define TIMER_MACROS_SVH

// Register offsets from FF04
`define TIMER_ADDR_W        2
`define TIMER_OFS_DIV       2'd0
`define TIMER_OFS_TIMA      2'd1
`define TIMER_OFS_TMA       2'd2
`define TIMER_OFS_TAC       2'd3

// Datapath widths
`define TIMER_DATA_W        8
`define TIMER_SYS_W         16
`define TIMER_PRESCALE_W    10
`define TIMER_TAC_W         3

// TIMA periods in iClock cycles, indexed by the TAC speed code
`define TIMER_PERIOD_SPEED0 1024
`define TIMER_PERIOD_SPEED1 16
`define TIMER_PERIOD_SPEED2 64
`define TIMER_PERIOD_SPEED3 256

`endif

// File: timer_pkg.sv
`default_nettype none

`include "timer_macros.svh"

package timer_pkg;

    // Register index, offset from FF04
    typedef enum logic [`TIMER_ADDR_W-1:0]
    {
        REG_DIV  = `TIMER_OFS_DIV,
        REG_TIMA = `TIMER_OFS_TIMA,
        REG_TMA  = `TIMER_OFS_TMA,
        REG_TAC  = `TIMER_OFS_TAC
    } regAddr_e;

    // One CPU access, held stable while req is high
    typedef struct packed {
        logic                     write;
        regAddr_e                 addr;
        logic [`TIMER_DATA_W-1:0] wdata;
    } regReq_t;

    // Single-cycle write strobe towards the counter units
    typedef struct packed {
        logic                     valid;
        regAddr_e                 addr;
        logic [`TIMER_DATA_W-1:0] data;
    } regWrite_t;

    // TAC bit 2 is enable, bits 1:0 select the speed
    typedef struct packed {
        logic       enable;
        logic [1:0] speed;
    } tacCfg_t;

    // Read-back view of all four registers
    typedef struct packed {
        logic [`TIMER_DATA_W-1:0] div;
        logic [`TIMER_DATA_W-1:0] tima;
        logic [`TIMER_DATA_W-1:0] tma;
        logic [`TIMER_DATA_W-1:0] tac;
    } timerRegs_t;

endpackage

`default_nettype wire
